// ==== logic/drs_defines.svh ====
`ifndef DRS_DEFINES_SVH
`define DRS_DEFINES_SVH

// ------------------------------
// datapath widths
// ------------------------------

// adc sample, also the fifo word payload
`define DRS_ADC_W        14
// samples per channel counter
`define DRS_SAMPLE_W     10
// stop cell as clocked out on srout
`define DRS_STOP_CELL_W  10
// adc pipeline delay setting
`define DRS_LATENCY_W    6

// ------------------------------
// chip constants
// ------------------------------

// channels 0..7 plus the clock channel 8
`define DRS_CHN_N        9
`define DRS_CHN_W        4
// config and write shift register length
`define DRS_SR_W         8
// about 1.5 domino turns before triggers are armed
`define DRS_START_CYCLES 105
// bits 3..7 of the config register must be written as one
`define DRS_CONFIG_FORCE 8'hf8

`endif

// ==== logic/drs_types_pkg.sv ====
package drs_types_pkg;

  // ------------------------------
  // readout sequencer
  // ------------------------------

  typedef enum logic [3:0] {
    INIT,
    IDLE,
    START_RUNNING,
    RUNNING,
    TRIGGER,
    INIT_READOUT,
    RSR_LOAD,
    ADC_READOUT,
    STOP_CELL,
    DONE,
    CONFIGURE
  } drs_state_e;

  // ------------------------------
  // drs4 address pins
  // ------------------------------

  // register select codes from the datasheet
  // channels 0..8 share the same pins as plain numbers
  typedef enum logic [3:0] {
    READ_SR  = 4'b1011,
    CONFIG   = 4'b1100,
    WRITE_SR = 4'b1101
  } drs_addr_e;

endpackage

// ==== logic/drs_io_pkg.sv ====
`include "drs_defines.svh"

package drs_io_pkg;

  // ------------------------------
  // control settings
  // ------------------------------

  // levels from the slow control side
  typedef struct packed {
    // 1 = continuous domino, 0 = single shot
    logic                        dmode;
    // srclk count before adc data is valid
    logic [`DRS_LATENCY_W-1:0]   adc_latency;
    // samples per channel minus one
    logic [`DRS_SAMPLE_W-1:0]    sample_count_max;
    // dmode, pllen, wsrloop in the low bits
    logic [`DRS_SR_W-1:0]        config_reg;
    // write shift register pattern
    logic [`DRS_SR_W-1:0]        chn_config;
    // one bit per channel 0..7
    logic [7:0]                  readout_mask;
  } drs_ctl_t;

  // ------------------------------
  // chip pins
  // ------------------------------

  typedef struct packed {
    logic [3:0] addr;
    logic       nreset;
    logic       denable;
    logic       dwrite;
    logic       rsrload;
    logic       srclk_en;
    logic       srin;
  } drs_pins_t;

  // output fifo write port, always ready
  typedef struct packed {
    logic                  wen;
    logic [`DRS_ADC_W-1:0] wdata;
  } fifo_wr_t;

endpackage

// ==== logic/drs_channel_mask.sv ====
`timescale 1ns/1ps
`include "drs_defines.svh"

module drs_channel_mask (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [7:0]            readout_mask_i,
  input  logic                  mask_load_i,
  input  logic                  mask_advance_i,
  output logic [`DRS_CHN_W-1:0] first_chn_o,
  output logic [`DRS_CHN_W-1:0] last_chn_o,
  output logic [`DRS_CHN_W-1:0] next_chn_o
);

  logic [`DRS_CHN_N-1:0] ext_mask;
  logic [`DRS_CHN_N-1:0] pending_q;
  logic [`DRS_CHN_N-1:0] after_cur;
  logic [`DRS_CHN_W-1:0] first_d;
  logic [`DRS_CHN_W-1:0] last_d;

  // channel 8 is read whenever anything else is
  assign ext_mask = {|readout_mask_i, readout_mask_i};

  // lowest pending bit is the channel being read, drop it
  assign after_cur = pending_q & (pending_q - 1'b1);

  // ------------------------------
  // priority search
  // ------------------------------

  always_comb begin
    first_d    = '0;
    last_d     = '0;
    next_chn_o = '0;
    // downward scan leaves the lowest set index
    for (int i = `DRS_CHN_N - 1; i >= 0; i--) begin
      if (ext_mask[i])
        first_d = `DRS_CHN_W'(i);
      if (after_cur[i])
        next_chn_o = `DRS_CHN_W'(i);
    end
    // upward scan leaves the highest
    for (int i = 0; i < `DRS_CHN_N; i++) begin
      if (ext_mask[i])
        last_d = `DRS_CHN_W'(i);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      first_chn_o <= '0;
      last_chn_o  <= '0;
      pending_q   <= '0;
    end else if (mask_load_i) begin
      first_chn_o <= first_d;
      last_chn_o  <= last_d;
      pending_q   <= ext_mask;
    end else if (mask_advance_i) begin
      pending_q   <= after_cur;
    end
  end

  // sequencer advances only while channels remain
  assert property (@(posedge clock) disable iff (reset)
    mask_advance_i |-> pending_q != '0);

endmodule

// ==== logic/drs_serial_config.sv ====
`timescale 1ns/1ps
`include "drs_defines.svh"

module drs_serial_config (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 cfg_start_i,
  input  logic [`DRS_SR_W-1:0] config_i,
  input  logic [`DRS_SR_W-1:0] chn_config_i,
  output logic                 srclk_en_o,
  output logic                 srin_o,
  output logic                 byte_sel_o,
  output logic                 cfg_done_o
);

  localparam int BIT_W = $clog2(`DRS_SR_W);

  logic [`DRS_SR_W-1:0] sr_q;
  logic [BIT_W-1:0]     bit_q;
  logic                 active_q;
  logic                 last_bit;

  assign last_bit = (bit_q == BIT_W'(`DRS_SR_W - 1));

  // chip shifts on srclk, msb goes first
  assign srclk_en_o = active_q;
  assign srin_o     = active_q & sr_q[`DRS_SR_W-1];

  // ------------------------------
  // byte and bit sequencing
  // ------------------------------

  // byte_sel 0 = config register, 1 = write shift register
  always_ff @(posedge clock) begin
    if (reset) begin
      active_q   <= 1'b0;
      bit_q      <= '0;
      byte_sel_o <= 1'b0;
      cfg_done_o <= 1'b0;
    end else begin
      cfg_done_o <= 1'b0;
      if (cfg_start_i) begin
        active_q   <= 1'b1;
        bit_q      <= '0;
        byte_sel_o <= 1'b0;
      end else if (active_q) begin
        // counter wraps to zero for the second byte
        bit_q <= bit_q + 1'b1;
        if (last_bit) begin
          if (byte_sel_o) begin
            active_q   <= 1'b0;
            cfg_done_o <= 1'b1;
          end else begin
            byte_sel_o <= 1'b1;
          end
        end
      end
    end
  end

  // shift data
  always_ff @(posedge clock) begin
    if (cfg_start_i)
      // reserved bits forced high
      sr_q <= config_i | `DRS_CONFIG_FORCE;
    else if (active_q && last_bit)
      sr_q <= chn_config_i;
    else if (active_q)
      sr_q <= {sr_q[`DRS_SR_W-2:0], 1'b0};
  end

endmodule

// ==== logic/drs_sample_capture.sv ====
`timescale 1ns/1ps
`include "drs_defines.svh"

module drs_sample_capture (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        chn_start_i,
  input  logic                        first_chn_i,
  input  logic [`DRS_LATENCY_W-1:0]   adc_latency_i,
  input  logic [`DRS_SAMPLE_W-1:0]    sample_count_max_i,
  input  logic [`DRS_ADC_W-1:0]       adc_data_i,
  input  logic                        srout_i,
  output logic                        srclk_en_o,
  output drs_io_pkg::fifo_wr_t        fifo_o,
  output logic [`DRS_STOP_CELL_W-1:0] stop_cell_o,
  output logic                        chn_done_o
);

  // room for sample_count_max plus the latency tail
  localparam int CNT_W = `DRS_SAMPLE_W + 1;

  logic [`DRS_ADC_W-1:0]    adc_q;
  logic                     run_q;
  logic [CNT_W-1:0]         cnt_q;
  logic [`DRS_SAMPLE_W-1:0] sample_q;
  logic                     past_latency;

  // srclk for exactly sample_count_max+1 cycles
  assign srclk_en_o   = run_q && (cnt_q <= CNT_W'(sample_count_max_i));
  // adc output trails srclk by the programmed latency
  assign past_latency = run_q && (cnt_q > CNT_W'(adc_latency_i));

  // ------------------------------
  // per channel counters
  // ------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      run_q      <= 1'b0;
      cnt_q      <= '0;
      sample_q   <= '0;
      chn_done_o <= 1'b0;
      fifo_o.wen <= 1'b0;
    end else begin
      chn_done_o <= 1'b0;
      fifo_o.wen <= past_latency;
      if (chn_start_i) begin
        run_q    <= 1'b1;
        cnt_q    <= '0;
        sample_q <= '0;
      end else if (run_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (past_latency) begin
          sample_q <= sample_q + 1'b1;
          // last word of this channel
          if (sample_q == sample_count_max_i) begin
            run_q      <= 1'b0;
            chn_done_o <= 1'b1;
          end
        end
      end
    end
  end

  // ------------------------------
  // data path
  // ------------------------------

  always_ff @(posedge clock) begin
    adc_q        <= adc_data_i;
    fifo_o.wdata <= adc_q;
    // rsrload put the stop cell msb on srout, rest follows per srclk
    if (first_chn_i && srclk_en_o && cnt_q < CNT_W'(`DRS_STOP_CELL_W))
      stop_cell_o <= {stop_cell_o[`DRS_STOP_CELL_W-2:0], srout_i};
  end

  // counters in step, so no word before the adc pipeline has filled
  assert property (@(posedge clock) disable iff (reset)
    fifo_o.wen |-> $past(cnt_q) ==
      CNT_W'($past(adc_latency_i)) + CNT_W'($past(sample_q)) + 1'b1);

endmodule

// ==== logic/drs_sequencer.sv ====
`timescale 1ns/1ps
`include "drs_defines.svh"

module drs_sequencer (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        trigger_i,
  input  drs_io_pkg::drs_ctl_t        ctl_i,
  input  logic                        start_i,
  input  logic                        reinit_i,
  input  logic                        configure_i,
  // channel mask
  input  logic [`DRS_CHN_W-1:0]       first_chn_i,
  input  logic [`DRS_CHN_W-1:0]       last_chn_i,
  input  logic [`DRS_CHN_W-1:0]       next_chn_i,
  output logic                        mask_load_o,
  output logic                        mask_advance_o,
  // serial config
  output logic                        cfg_start_o,
  input  logic                        cfg_srclk_en_i,
  input  logic                        cfg_srin_i,
  input  logic                        cfg_byte_sel_i,
  input  logic                        cfg_done_i,
  // sample capture
  output logic                        chn_start_o,
  output logic                        capture_first_o,
  input  logic                        cap_srclk_en_i,
  input  logic                        chn_done_i,
  // chip and status
  output drs_io_pkg::drs_pins_t       pins_o,
  output logic                        busy_o,
  output logic                        readout_complete_o,
  input  logic [`DRS_STOP_CELL_W-1:0] stop_cell_i,
  output logic [`DRS_STOP_CELL_W-1:0] stop_cell_o
);

  import drs_types_pkg::*;

  localparam int TIMER_W = $clog2(`DRS_START_CYCLES);

  drs_state_e            state_q;
  logic [TIMER_W-1:0]    timer_q;
  logic                  reinit_q;
  logic [3:0]            addr_q;
  logic                  nreset_q;
  logic                  denable_q;
  logic                  dwrite_q;
  logic                  rsrload_q;
  logic [`DRS_CHN_W-1:0] chn_q;
  logic                  first_q;
  logic                  trig_ok;

  // zero mask blocks both trigger and single shot
  assign trig_ok = (trigger_i || !ctl_i.dmode) && (|ctl_i.readout_mask);

  assign cfg_start_o     = (state_q == IDLE) && !reinit_q && configure_i;
  assign mask_load_o     = (state_q == TRIGGER);
  assign mask_advance_o  = (state_q == ADC_READOUT) && chn_done_i && (chn_q != last_chn_i);
  assign capture_first_o = first_q;

  // ------------------------------
  // pin mux
  // ------------------------------

  always_comb begin
    pins_o.addr     = addr_q;
    pins_o.nreset   = nreset_q;
    pins_o.denable  = denable_q;
    pins_o.dwrite   = dwrite_q;
    pins_o.rsrload  = rsrload_q;
    pins_o.srclk_en = (state_q == ADC_READOUT) && cap_srclk_en_i;
    pins_o.srin     = 1'b0;
    // serial block owns the shift pins while configuring
    if (state_q == CONFIGURE) begin
      pins_o.addr     = cfg_byte_sel_i ? WRITE_SR : CONFIG;
      pins_o.srclk_en = cfg_srclk_en_i;
      pins_o.srin     = cfg_srin_i;
    end
  end

  // ------------------------------
  // state machine
  // ------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q            <= INIT;
      timer_q            <= '0;
      reinit_q           <= 1'b0;
      addr_q             <= CONFIG;
      nreset_q           <= 1'b0;
      denable_q          <= 1'b0;
      dwrite_q           <= 1'b0;
      rsrload_q          <= 1'b0;
      chn_start_o        <= 1'b0;
      chn_q              <= '0;
      first_q            <= 1'b0;
      busy_o             <= 1'b0;
      readout_complete_o <= 1'b0;
      stop_cell_o        <= '0;
    end else begin
      rsrload_q          <= 1'b0;
      chn_start_o        <= 1'b0;
      readout_complete_o <= 1'b0;

      // reinit is a pulse, hold it until INIT sees it
      if (reinit_i)
        reinit_q <= 1'b1;
      else if (state_q == INIT)
        reinit_q <= 1'b0;

      if (reinit_q && state_q != INIT) begin
        state_q   <= INIT;
        timer_q   <= '0;
        nreset_q  <= 1'b0;
        denable_q <= 1'b0;
        dwrite_q  <= 1'b0;
        first_q   <= 1'b0;
        busy_o    <= 1'b0;
      end else begin
        case (state_q)
          INIT: begin
            // datasheet asks for a two cycle reset pulse
            timer_q <= timer_q + 1'b1;
            if (timer_q == TIMER_W'(1)) begin
              state_q  <= IDLE;
              timer_q  <= '0;
              nreset_q <= 1'b1;
            end
          end
          IDLE: begin
            nreset_q  <= 1'b1;
            addr_q    <= READ_SR;
            denable_q <= 1'b0;
            dwrite_q  <= 1'b0;
            busy_o    <= 1'b0;
            timer_q   <= '0;
            if (cfg_start_o) begin
              state_q <= CONFIGURE;
            end else if (start_i) begin
              state_q <= START_RUNNING;
              busy_o  <= 1'b1;
            end
          end
          START_RUNNING: begin
            // domino on and sampling
            denable_q <= 1'b1;
            dwrite_q  <= 1'b1;
            timer_q   <= timer_q + 1'b1;
            if (timer_q == TIMER_W'(`DRS_START_CYCLES - 1))
              state_q <= RUNNING;
          end
          RUNNING: begin
            if (trig_ok) begin
              // freeze the sampling cells
              state_q  <= TRIGGER;
              dwrite_q <= 1'b0;
            end
          end
          TRIGGER: begin
            first_q <= 1'b1;
            state_q <= INIT_READOUT;
          end
          INIT_READOUT: begin
            // channel on addr one cycle ahead of rsrload
            if (first_q) begin
              chn_q  <= first_chn_i;
              addr_q <= first_chn_i;
            end else begin
              addr_q <= chn_q;
            end
            state_q <= RSR_LOAD;
          end
          RSR_LOAD: begin
            rsrload_q   <= 1'b1;
            chn_start_o <= 1'b1;
            state_q     <= ADC_READOUT;
          end
          ADC_READOUT: begin
            if (chn_done_i) begin
              first_q <= 1'b0;
              if (chn_q == last_chn_i) begin
                state_q <= STOP_CELL;
              end else begin
                chn_q   <= next_chn_i;
                state_q <= INIT_READOUT;
              end
            end
          end
          STOP_CELL: begin
            stop_cell_o <= stop_cell_i;
            addr_q      <= READ_SR;
            state_q     <= DONE;
          end
          DONE: begin
            // restart sampling right away, keeps the chip warm
            readout_complete_o <= 1'b1;
            dwrite_q           <= 1'b1;
            timer_q            <= '0;
            state_q            <= START_RUNNING;
          end
          CONFIGURE: begin
            if (cfg_done_i)
              state_q <= IDLE;
          end
          default: begin
            state_q <= INIT;
          end
        endcase
      end
    end
  end

  // read shift register load and shift clock must not overlap
  assert property (@(posedge clock) disable iff (reset)
    !(pins_o.rsrload && pins_o.srclk_en));

endmodule

// ==== logic/drs_readout_top.sv ====
`timescale 1ns/1ps
`include "drs_defines.svh"

module drs_readout_top (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        trigger_i,
  input  logic [`DRS_ADC_W-1:0]       adc_data_i,
  input  drs_io_pkg::drs_ctl_t        ctl_i,
  input  logic                        start_i,
  input  logic                        reinit_i,
  input  logic                        configure_i,
  input  logic                        srout_i,
  output drs_io_pkg::drs_pins_t       pins_o,
  output drs_io_pkg::fifo_wr_t        fifo_o,
  output logic [`DRS_STOP_CELL_W-1:0] stop_cell_o,
  output logic                        readout_complete_o,
  output logic                        busy_o
);

  // mask lookups
  logic [`DRS_CHN_W-1:0]       first_chn;
  logic [`DRS_CHN_W-1:0]       last_chn;
  logic [`DRS_CHN_W-1:0]       next_chn;
  logic                        mask_load;
  logic                        mask_advance;
  // serial config handshake
  logic                        cfg_start;
  logic                        cfg_srclk_en;
  logic                        cfg_srin;
  logic                        cfg_byte_sel;
  logic                        cfg_done;
  // capture handshake
  logic                        chn_start;
  logic                        capture_first;
  logic                        cap_srclk_en;
  logic                        chn_done;
  logic [`DRS_STOP_CELL_W-1:0] cap_stop_cell;

  drs_sequencer u_sequencer (
    .clock              (clock),
    .reset              (reset),
    .trigger_i          (trigger_i),
    .ctl_i              (ctl_i),
    .start_i            (start_i),
    .reinit_i           (reinit_i),
    .configure_i        (configure_i),
    .first_chn_i        (first_chn),
    .last_chn_i         (last_chn),
    .next_chn_i         (next_chn),
    .mask_load_o        (mask_load),
    .mask_advance_o     (mask_advance),
    .cfg_start_o        (cfg_start),
    .cfg_srclk_en_i     (cfg_srclk_en),
    .cfg_srin_i         (cfg_srin),
    .cfg_byte_sel_i     (cfg_byte_sel),
    .cfg_done_i         (cfg_done),
    .chn_start_o        (chn_start),
    .capture_first_o    (capture_first),
    .cap_srclk_en_i     (cap_srclk_en),
    .chn_done_i         (chn_done),
    .pins_o             (pins_o),
    .busy_o             (busy_o),
    .readout_complete_o (readout_complete_o),
    .stop_cell_i        (cap_stop_cell),
    .stop_cell_o        (stop_cell_o)
  );

  drs_channel_mask u_channel_mask (
    .clock          (clock),
    .reset          (reset),
    .readout_mask_i (ctl_i.readout_mask),
    .mask_load_i    (mask_load),
    .mask_advance_i (mask_advance),
    .first_chn_o    (first_chn),
    .last_chn_o     (last_chn),
    .next_chn_o     (next_chn)
  );

  drs_serial_config u_serial_config (
    .clock        (clock),
    .reset        (reset),
    .cfg_start_i  (cfg_start),
    .config_i     (ctl_i.config_reg),
    .chn_config_i (ctl_i.chn_config),
    .srclk_en_o   (cfg_srclk_en),
    .srin_o       (cfg_srin),
    .byte_sel_o   (cfg_byte_sel),
    .cfg_done_o   (cfg_done)
  );

  drs_sample_capture u_sample_capture (
    .clock              (clock),
    .reset              (reset),
    .chn_start_i        (chn_start),
    .first_chn_i        (capture_first),
    .adc_latency_i      (ctl_i.adc_latency),
    .sample_count_max_i (ctl_i.sample_count_max),
    .adc_data_i         (adc_data_i),
    .srout_i            (srout_i),
    .srclk_en_o         (cap_srclk_en),
    .fifo_o             (fifo_o),
    .stop_cell_o        (cap_stop_cell),
    .chn_done_o         (chn_done)
  );

endmodule

// ==== test/drs_tb_checks.svh ====
`ifndef DRS_TB_CHECKS_SVH
`define DRS_TB_CHECKS_SVH

// ------------------------------
// error counters
// ------------------------------

int pin_errors   = 0;
int fifo_errors  = 0;
int stop_errors  = 0;
int count_errors = 0;
int flag_errors  = 0;

// all pin fields, compared as one word
task automatic check_pins(input string what, input drs_pins_t got, input drs_pins_t exp);
  if (got !== exp) begin
    pin_errors++;
    $display("Error: pins_o %s got %h, expected %h", what, got, exp);
  end
endtask

task automatic check_fifo(input drs_io_pkg::fifo_wr_t got, input drs_io_pkg::fifo_wr_t exp);
  if (got !== exp) begin
    fifo_errors++;
    $display("Error: fifo_o got wen %h wdata %h, expected wen %h wdata %h",
             got.wen, got.wdata, exp.wen, exp.wdata);
  end
endtask

task automatic check_stop_cell(input logic [`DRS_STOP_CELL_W-1:0] got,
                               input logic [`DRS_STOP_CELL_W-1:0] exp);
  if (got !== exp) begin
    stop_errors++;
    $display("Error: stop_cell_o got %h, expected %h", got, exp);
  end
endtask

// word counts, pulse counts and channel numbers
task automatic check_count(input string what, input int got, input int exp);
  if (got != exp) begin
    count_errors++;
    $display("Error: %s got %h, expected %h", what, got, exp);
  end
endtask

// single bit status outputs
task automatic check_flag(input string what, input logic got, input logic exp);
  if (got !== exp) begin
    flag_errors++;
    $display("Error: %s got %h, expected %h", what, got, exp);
  end
endtask

`endif

// ==== test/drs_readout_tb.sv ====
`timescale 1ns/1ps
`include "drs_defines.svh"

module drs_readout_tb;

  import drs_types_pkg::*;
  import drs_io_pkg::*;

  `include "drs_tb_checks.svh"

  logic                        clock;
  logic                        reset;
  logic                        trigger_i;
  logic [`DRS_ADC_W-1:0]       adc_data_i;
  drs_ctl_t                    ctl_i;
  logic                        start_i;
  logic                        reinit_i;
  logic                        configure_i;
  logic                        srout_i;
  drs_pins_t                   pins_o;
  fifo_wr_t                    fifo_o;
  logic [`DRS_STOP_CELL_W-1:0] stop_cell_o;
  logic                        readout_complete_o;
  logic                        busy_o;

  // case count, then 7 words per case
  logic [31:0] stim_mem [0:127];
  integer      seed = 32'h2494;
  int          cycles = 0;
  int          cycle_limit = 100000;

  // monitor state
  logic [15:0]                 exp_cfg_word;
  int                          cfg_count;
  logic [`DRS_STOP_CELL_W-1:0] exp_stop;
  int                          srout_idx;
  int                          words;
  int                          fifo_total;
  int                          complete_cnt;
  bit                          have_chn;
  logic [3:0]                  chn_addrs[$];
  logic [`DRS_ADC_W-1:0]       adc_h1;
  logic [`DRS_ADC_W-1:0]       adc_h2;

  drs_readout_top u_dut (
    .clock              (clock),
    .reset              (reset),
    .trigger_i          (trigger_i),
    .adc_data_i         (adc_data_i),
    .ctl_i              (ctl_i),
    .start_i            (start_i),
    .reinit_i           (reinit_i),
    .configure_i        (configure_i),
    .srout_i            (srout_i),
    .pins_o             (pins_o),
    .fifo_o             (fifo_o),
    .stop_cell_o        (stop_cell_o),
    .readout_complete_o (readout_complete_o),
    .busy_o             (busy_o)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // ------------------------------
  // stimulus on the falling edge
  // ------------------------------

  // fresh adc word every cycle
  always @(negedge clock)
    adc_data_i <= $random(seed);

  // chip model, stop cell msb first after rsrload
  always @(negedge clock)
    srout_i <= (srout_idx < `DRS_STOP_CELL_W) ? exp_stop[`DRS_STOP_CELL_W-1-srout_idx] : 1'b0;

  always @(posedge clock) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Run stopped: cycle limit %0d reached before the tests finished", cycle_limit);
      $display("Testbench failed");
      $finish;
    end
  end

  // ------------------------------
  // monitor, samples pre edge values
  // ------------------------------

  always @(posedge clock) begin
    drs_pins_t exp_pins;
    fifo_wr_t  exp_fifo;
    if (!reset) begin
      // serial config, only while not busy, domino still off
      if (pins_o.srclk_en && !busy_o) begin
        exp_pins          = '0;
        exp_pins.addr     = (cfg_count < 8) ? CONFIG : WRITE_SR;
        exp_pins.nreset   = 1'b1;
        exp_pins.srclk_en = 1'b1;
        exp_pins.srin     = exp_cfg_word[15-cfg_count];
        check_pins("config shift", pins_o, exp_pins);
        cfg_count++;
      end
      // new channel starts with rsrload
      if (pins_o.rsrload) begin
        chn_addrs.push_back(pins_o.addr);
        if (have_chn)
          check_count("fifo words per channel", words, ctl_i.sample_count_max + 1);
        words     = 0;
        have_chn  = 1;
        srout_idx = 0;
      end else if (pins_o.srclk_en && busy_o) begin
        srout_idx++;
      end
      if (fifo_o.wen) begin
        exp_fifo.wen   = 1'b1;
        exp_fifo.wdata = adc_h2;
        check_fifo(fifo_o, exp_fifo);
        words++;
        fifo_total++;
      end
      if (readout_complete_o) begin
        complete_cnt++;
        check_count("fifo words per channel", words, ctl_i.sample_count_max + 1);
        have_chn = 0;
        check_stop_cell(stop_cell_o, exp_stop);
      end
    end
    adc_h2 = adc_h1;
    adc_h1 = adc_data_i;
  end

  // ------------------------------
  // test sequence
  // ------------------------------

  initial begin
    int        n_cases;
    int        base;
    logic [8:0] ext;
    logic [3:0] exp_chn[$];
    clock_init: begin
      reset       = 1'b1;
      trigger_i   = 1'b0;
      adc_data_i  = '0;
      ctl_i       = '0;
      start_i     = 1'b0;
      reinit_i    = 1'b0;
      configure_i = 1'b0;
      srout_i     = 1'b0;
      cfg_count   = 0;
      srout_idx   = 99;
      exp_stop    = '0;
      words       = 0;
      fifo_total  = 0;
      have_chn    = 0;
      complete_cnt = 0;
    end
    $readmemh("test/drs_stim.txt", stim_mem);
    n_cases = stim_mem[0];
    // limit from warm-up, channel lengths and slack
    cycle_limit = 400;
    for (int k = 0; k < n_cases; k++)
      cycle_limit += 2 * `DRS_START_CYCLES + 300 + 9 * (stim_mem[1+7*k+2] + 80);

    repeat (16) @(negedge clock);
    reset = 1'b0;
    while (!pins_o.nreset) @(negedge clock);

    for (int k = 0; k < n_cases; k++) begin
      base = 1 + 7 * k;
      ctl_i.dmode            = stim_mem[base][0];
      ctl_i.adc_latency      = stim_mem[base+1];
      ctl_i.sample_count_max = stim_mem[base+2];
      ctl_i.readout_mask     = stim_mem[base+3];
      ctl_i.config_reg       = stim_mem[base+4];
      ctl_i.chn_config       = stim_mem[base+5];
      exp_stop               = stim_mem[base+6];

      // each case loads its own config bytes from idle
      exp_cfg_word = {stim_mem[base+4][7:0] | 8'hf8, stim_mem[base+5][7:0]};
      cfg_count    = 0;
      configure_i  = 1'b1;
      @(negedge clock);
      configure_i = 1'b0;
      while (cfg_count < 16) @(negedge clock);
      repeat (4) @(negedge clock);
      check_count("config srclk cycles", cfg_count, 16);

      // channel 8 joins any nonzero mask
      ext = {|stim_mem[base+3][7:0], stim_mem[base+3][7:0]};
      exp_chn.delete();
      for (int c = 0; c < 9; c++)
        if (ext[c])
          exp_chn.push_back(c);
      chn_addrs.delete();
      complete_cnt = 0;
      fifo_total   = 0;

      start_i = 1'b1;
      @(negedge clock);
      start_i   = 1'b0;
      trigger_i = ctl_i.dmode;
      if (ext == '0) begin
        repeat (`DRS_START_CYCLES + 60) @(negedge clock);
        check_count("fifo words with empty mask", fifo_total, 0);
      end else begin
        while (complete_cnt == 0) @(negedge clock);
        trigger_i = 1'b0;
        repeat (5) @(negedge clock);
      end
      check_flag("busy_o", busy_o, 1'b1);
      check_count("readout_complete pulses", complete_cnt, (ext == '0) ? 0 : 1);
      check_count("channel count", chn_addrs.size(), exp_chn.size());
      foreach (exp_chn[i])
        if (i < chn_addrs.size())
          check_count("channel address", chn_addrs[i], exp_chn[i]);

      // back to idle through reinit
      trigger_i = 1'b0;
      reinit_i  = 1'b1;
      @(negedge clock);
      reinit_i = 1'b0;
      while (pins_o.nreset) @(negedge clock);
      while (!pins_o.nreset) @(negedge clock);
      repeat (2) @(negedge clock);
      check_flag("busy_o", busy_o, 1'b0);
    end

    $display("errors: pins %0d fifo %0d stop_cell %0d counts %0d flags %0d",
             pin_errors, fifo_errors, stop_errors, count_errors, flag_errors);
    if (pin_errors + fifo_errors + stop_errors + count_errors + flag_errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// ==== test/drs_stim.txt ====
// first word: number of cases
// then per case: dmode latency sample_count_max mask config chn_config stop_cell
5
// triggered, two channels plus channel 8
1 03 00f 05 01 a5 2b7
// single shot, channel 7 only
0 05 013 80 00 3c 155
// all channels, zero latency
1 00 009 ff 07 ff 3ff
// empty mask, trigger must be ignored
1 02 00c 00 00 00 000
// single shot, latency past the stop cell bits
0 08 00b 21 02 81 001

// ==== files.f ====
+incdir+logic
+incdir+test
logic/drs_types_pkg.sv
logic/drs_io_pkg.sv
logic/drs_channel_mask.sv
logic/drs_serial_config.sv
logic/drs_sample_capture.sv
logic/drs_sequencer.sv
logic/drs_readout_top.sv
test/drs_readout_tb.sv
